//--- vlog.f
+incdir+common
common/alu_op_pkg.sv
common/wb_regs_pkg.sv
common/alu_if.sv
alu/logic_op.sv
alu/arith_op.sv
alu/alu_core.sv
src/wb_alu_regs.sv
src/result_buf.sv
src/alu_top.sv
tests/alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ALU coprocessor testbench with Verilator
# Run from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module alu_tb \
    -o alu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/alu_sim)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only when the testbench printed its pass line
if echo "$sim_out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1

//--- tests/alu_tb.sv
`timescale 1ns/1ns

`include "alu_defs.svh"

module alu_tb;

    localparam int ACK_LIMIT  = 8;
    localparam int POLL_LIMIT = 16;

    logic                   soc_clk;
    logic                   arst_n;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`WB_ADR_W-1:0]   wb_adr;
    logic [`ALU_DATA_W-1:0] wb_dat_w;
    logic [`ALU_DATA_W-1:0] wb_dat_r;
    logic                   wb_ack;

    int tests_run;
    int tests_failed;
    int checks;
    int errors;

    alu_top dut0 (
        .soc_clk  (soc_clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    // 40 ns period
    always #20 soc_clk = ~soc_clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("TIMEOUT: %s", what);
        errors++;
    endtask

    // Called at a falling edge, returns at a falling edge
    task automatic bus_cycle(input logic we, input logic [`WB_ADR_W-1:0] adr,
                             input logic [`ALU_DATA_W-1:0] wdat,
                             output logic [`ALU_DATA_W-1:0] rdat);
        int waited;
        waited   = 0;
        rdat     = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(negedge soc_clk);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (!wb_ack) begin
            report_timeout("no wb_ack for a bus transfer");
        end else begin
            // Read data valid with ack
            rdat = wb_dat_r;
            check_value("wb_ack latency", waited, 1);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge soc_clk);
        // Ack lasts a single cycle
        check_value("wb_ack", {31'b0, wb_ack}, 0);
    endtask

    task automatic wb_write(input logic [`WB_ADR_W-1:0] adr, input logic [31:0] dat);
        logic [31:0] unused_rd;
        bus_cycle(1'b1, adr, dat, unused_rd);
    endtask

    task automatic wb_read(input logic [`WB_ADR_W-1:0] adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    // Poll status until the done bit shows up
    task automatic wait_done();
        logic [31:0] st;
        int polls;
        st    = '0;
        polls = 0;
        while (!st[wb_regs_pkg::STAT_DONE] && polls < POLL_LIMIT) begin
            wb_read(wb_regs_pkg::REG_STATUS, st);
            polls++;
        end
        if (!st[wb_regs_pkg::STAT_DONE]) begin
            report_timeout("done flag never set after a command");
        end
    endtask

    // Reference model from the opcode table
    function automatic logic [31:0] expected_result(input logic [4:0] op,
                                                    input logic [31:0] a, input logic [31:0] b);
        case (op)
            alu_op_pkg::OP_ADD:  return a + b;
            alu_op_pkg::OP_SUB:  return a - b;
            alu_op_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_op_pkg::OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            alu_op_pkg::OP_XOR:  return a ^ b;
            alu_op_pkg::OP_OR:   return a | b;
            alu_op_pkg::OP_AND:  return a & b;
            default:             return 32'd0;
        endcase
    endfunction

    function automatic logic is_legal(input logic [4:0] op);
        return op inside {5'd0, 5'd1, 5'd2, 5'd3, 5'd11, 5'd14, 5'd15};
    endfunction

    // Writes operands and opcode then checks result and flags after done
    task automatic run_op(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] exp;
        logic [31:0] res;
        logic [31:0] st;
        exp = expected_result(op, a, b);
        wb_write(wb_regs_pkg::REG_OPA, a);
        wb_write(wb_regs_pkg::REG_OPB, b);
        wb_write(wb_regs_pkg::REG_CMD, {27'b0, op});
        wait_done();
        wb_read(wb_regs_pkg::REG_RESULT, res);
        wb_read(wb_regs_pkg::REG_STATUS, st);
        check_value("result", res, exp);
        check_value("status.illegal", {31'b0, st[wb_regs_pkg::STAT_ILLEGAL]},
                    {31'b0, !is_legal(op)});
        check_value("status.zero", {31'b0, st[wb_regs_pkg::STAT_ZERO]}, {31'b0, exp == 0});
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %-10s failed with %0d errors", name, errors - errors_before);
        end else begin
            $display("test %-10s ok", name);
        end
    endtask

    initial begin
        int          err0;
        logic [31:0] rd;
        logic [31:0] a;
        logic [31:0] b;
        tests_run    = 0;
        tests_failed = 0;
        checks       = 0;
        errors       = 0;
        void'($urandom(22398));
        soc_clk      = 1'b0;
        arst_n       = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        repeat (16) @(negedge soc_clk);
        arst_n = 1'b1;
        @(negedge soc_clk);

        // Reset state
        err0 = errors;
        check_value("wb_ack", {31'b0, wb_ack}, 0);
        wb_read(wb_regs_pkg::REG_STATUS, rd);
        check_value("status", rd, 0);
        wb_read(wb_regs_pkg::REG_RESULT, rd);
        check_value("result", rd, 0);
        finish_test("reset", err0);

        // Bitwise group on random operands
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            run_op(alu_op_pkg::OP_XOR, $urandom, $urandom);
            run_op(alu_op_pkg::OP_OR, $urandom, $urandom);
            run_op(alu_op_pkg::OP_AND, $urandom, $urandom);
        end
        finish_test("logic", err0);

        // Wraparound in both directions and compares across the sign boundary
        err0 = errors;
        run_op(alu_op_pkg::OP_ADD, 32'hFFFF_FFF0 | ($urandom & 32'hF), 32'h20);
        run_op(alu_op_pkg::OP_SUB, 32'd5, 32'd9);
        run_op(alu_op_pkg::OP_ADD, $urandom, $urandom);
        run_op(alu_op_pkg::OP_SUB, $urandom, $urandom);
        for (int i = 0; i < 3; i++) begin
            a = $urandom | 32'h8000_0000;
            b = $urandom & 32'h7FFF_FFFF;
            run_op(alu_op_pkg::OP_SLT, a, b);
            run_op(alu_op_pkg::OP_SLTU, a, b);
            run_op(alu_op_pkg::OP_SLT, b, a);
            run_op(alu_op_pkg::OP_SLTU, b, a);
        end
        finish_test("arith", err0);

        // Unknown code sets illegal and the next legal code clears it
        err0 = errors;
        run_op(5'd7, $urandom, $urandom);
        run_op(alu_op_pkg::OP_ADD, $urandom, $urandom);
        finish_test("illegal", err0);

        // Equal operands cancel
        err0 = errors;
        a = $urandom;
        run_op(alu_op_pkg::OP_XOR, a, a);
        finish_test("zero", err0);

        // Register readback with ack timing checked on each transfer
        err0 = errors;
        a = $urandom;
        b = $urandom;
        wb_write(wb_regs_pkg::REG_OPA, a);
        wb_write(wb_regs_pkg::REG_OPB, b);
        wb_write(wb_regs_pkg::REG_CMD, 32'd14);
        wait_done();
        wb_read(wb_regs_pkg::REG_OPA, rd);
        check_value("opa", rd, a);
        wb_read(wb_regs_pkg::REG_OPB, rd);
        check_value("opb", rd, b);
        wb_read(wb_regs_pkg::REG_CMD, rd);
        check_value("cmd", rd, 32'd14);
        finish_test("readback", err0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- src/alu_top.sv
`timescale 1ns/1ns

`include "alu_defs.svh"

module alu_top (
    input  logic                   soc_clk,
    input  logic                   arst_n,
    // Wishbone classic slave port
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`WB_ADR_W-1:0]   wb_adr,
    input  logic [`ALU_DATA_W-1:0] wb_dat_w,
    output logic [`ALU_DATA_W-1:0] wb_dat_r,
    output logic                   wb_ack
);

    logic [`ALU_DATA_W-1:0] result;
    logic                   done;
    logic                   illegal;
    logic                   zero;
    logic                   busy;

    alu_req_if req_if ();
    alu_rsp_if rsp_if ();

    // Input side
    wb_alu_regs u_regs (
        .soc_clk (soc_clk),
        .arst_n  (arst_n),
        .cyc     (wb_cyc),
        .stb     (wb_stb),
        .we      (wb_we),
        .adr     (wb_adr),
        .dat_w   (wb_dat_w),
        .dat_r   (wb_dat_r),
        .ack     (wb_ack),
        .result  (result),
        .done    (done),
        .illegal (illegal),
        .zero    (zero),
        .busy    (busy),
        .req     (req_if.src)
    );

    // Processing part
    alu_core u_core (
        .soc_clk (soc_clk),
        .arst_n  (arst_n),
        .req     (req_if.dst),
        .rsp     (rsp_if.src),
        .busy    (busy)
    );

    // Output side, cleared by the same start pulse
    result_buf u_rbuf (
        .soc_clk (soc_clk),
        .arst_n  (arst_n),
        .rsp     (rsp_if.dst),
        .clear   (req_if.valid),
        .result  (result),
        .done    (done),
        .illegal (illegal),
        .zero    (zero)
    );

endmodule

//--- src/result_buf.sv
`timescale 1ns/1ns

`include "alu_defs.svh"

module result_buf (
    input  logic                   soc_clk,
    input  logic                   arst_n,
    alu_rsp_if.dst                 rsp,
    // Command issue pulse
    input  logic                   clear,
    output logic [`ALU_DATA_W-1:0] result,
    output logic                   done,
    output logic                   illegal,
    output logic                   zero
);

    always_ff @(posedge soc_clk or negedge arst_n) begin
        if (!arst_n) begin
            result  <= '0;
            done    <= 1'b0;
            illegal <= 1'b0;
            zero    <= 1'b0;
        end else begin
            // Latest response always wins
            if (rsp.valid) begin
                result <= rsp.result;
                zero   <= (rsp.result == '0);
                // Sticky until a legal opcode completes
                illegal <= rsp.illegal;
            end
            // New command pending, its result is not here yet
            if (clear) begin
                done <= 1'b0;
            end else if (rsp.valid) begin
                done <= 1'b1;
            end
        end
    end

endmodule

//--- src/wb_alu_regs.sv
`timescale 1ns/1ns

`include "alu_defs.svh"

module wb_alu_regs (
    input  logic                   soc_clk,
    input  logic                   arst_n,
    // Wishbone classic slave
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [`WB_ADR_W-1:0]   adr,
    input  logic [`ALU_DATA_W-1:0] dat_w,
    output logic [`ALU_DATA_W-1:0] dat_r,
    output logic                   ack,
    // Read-only group from the result buffer
    input  logic [`ALU_DATA_W-1:0] result,
    input  logic                   done,
    input  logic                   illegal,
    input  logic                   zero,
    input  logic                   busy,
    alu_req_if.src                 req
);

    logic                   bus_req;
    logic                   wr_en;
    logic [`ALU_DATA_W-1:0] opa_q;
    logic [`ALU_DATA_W-1:0] opb_q;
    logic [`ALU_OP_W-1:0]   cmd_q;
    logic [`ALU_STAT_W-1:0] status;

    // Request seen and not yet acknowledged
    assign bus_req = cyc & stb & ~ack;
    // Writes land on the same edge that raises ack
    assign wr_en = bus_req & we;

    always_ff @(posedge soc_clk or negedge arst_n) begin
        if (!arst_n) begin
            ack       <= 1'b0;
            req.valid <= 1'b0;
            opa_q     <= '0;
            opb_q     <= '0;
            cmd_q     <= '0;
        end else begin
            // One-cycle ack, drops after a single high cycle
            ack <= bus_req;
            // Start pulse for a CMD write
            req.valid <= wr_en && (adr == wb_regs_pkg::REG_CMD);
            if (wr_en) begin
                case (wb_regs_pkg::wb_reg_e'(adr))
                    wb_regs_pkg::REG_OPA: opa_q <= dat_w;
                    wb_regs_pkg::REG_OPB: opb_q <= dat_w;
                    wb_regs_pkg::REG_CMD: cmd_q <= dat_w[`ALU_OP_W-1:0];
                    // Status and result ignore writes
                    default: ;
                endcase
            end
        end
    end

    // Operands and opcode held stable for the core
    assign req.op   = cmd_q;
    assign req.dat1 = opa_q;
    assign req.dat2 = opb_q;

    // Flag bits at their map positions
    always_comb begin
        status                            = '0;
        status[wb_regs_pkg::STAT_DONE]    = done;
        status[wb_regs_pkg::STAT_ILLEGAL] = illegal;
        status[wb_regs_pkg::STAT_ZERO]    = zero;
        status[wb_regs_pkg::STAT_BUSY]    = busy;
    end

    // Read mux, valid while ack is high
    always_comb begin
        case (wb_regs_pkg::wb_reg_e'(adr))
            wb_regs_pkg::REG_OPA:    dat_r = opa_q;
            wb_regs_pkg::REG_OPB:    dat_r = opb_q;
            wb_regs_pkg::REG_CMD:    dat_r = {{(`ALU_DATA_W-`ALU_OP_W){1'b0}}, cmd_q};
            wb_regs_pkg::REG_STATUS: dat_r = {{(`ALU_DATA_W-`ALU_STAT_W){1'b0}}, status};
            wb_regs_pkg::REG_RESULT: dat_r = result;
            // Unmapped words read as zero
            default:                 dat_r = '0;
        endcase
    end

endmodule

//--- alu/alu_core.sv
`timescale 1ns/1ns

`include "alu_defs.svh"

module alu_core (
    input  logic   soc_clk,
    input  logic   arst_n,
    alu_req_if.dst req,
    alu_rsp_if.src rsp,
    output logic   busy
);

    alu_op_pkg::alu_op_e    op;
    alu_op_pkg::alu_stage_e stage;
    logic [`ALU_DATA_W-1:0] logic_out;
    logic [`ALU_DATA_W-1:0] arith_out;
    logic [`ALU_DATA_W-1:0] sel_result;
    logic                   sel_illegal;
    logic [`ALU_DATA_W-1:0] result_q;
    logic                   illegal_q;

    // Raw code taken as an opcode, unknown values pass through
    assign op = alu_op_pkg::alu_op_e'(req.op);

    logic_op u_logic_op (
        .dat1      (req.dat1),
        .dat2      (req.dat2),
        .op        (op),
        .logic_out (logic_out)
    );

    arith_op u_arith_op (
        .dat1      (req.dat1),
        .dat2      (req.dat2),
        .op        (op),
        .arith_out (arith_out)
    );

    // Unit select, unknown codes give zero and flag illegal
    always_comb begin
        sel_result  = '0;
        sel_illegal = 1'b0;
        case (op)
            alu_op_pkg::OP_ADD,
            alu_op_pkg::OP_SUB,
            alu_op_pkg::OP_SLT,
            alu_op_pkg::OP_SLTU: sel_result = arith_out;
            alu_op_pkg::OP_XOR,
            alu_op_pkg::OP_OR,
            alu_op_pkg::OP_AND:  sel_result = logic_out;
            default:             sel_illegal = 1'b1;
        endcase
    end

    // One registered stage, new request accepted every cycle
    always_ff @(posedge soc_clk or negedge arst_n) begin
        if (!arst_n) begin
            stage     <= alu_op_pkg::STAGE_IDLE;
            result_q  <= '0;
            illegal_q <= 1'b0;
        end else begin
            stage <= req.valid ? alu_op_pkg::STAGE_BUSY : alu_op_pkg::STAGE_IDLE;
            if (req.valid) begin
                result_q  <= sel_result;
                illegal_q <= sel_illegal;
            end
        end
    end

    // Busy stage means a fresh result on the output
    assign rsp.valid   = (stage == alu_op_pkg::STAGE_BUSY);
    assign rsp.result  = result_q;
    assign rsp.illegal = illegal_q;
    assign busy        = (stage == alu_op_pkg::STAGE_BUSY);

endmodule

//--- alu/arith_op.sv
`timescale 1ns/1ns

`include "alu_defs.svh"

module arith_op (
    input  logic [`ALU_DATA_W-1:0] dat1,
    input  logic [`ALU_DATA_W-1:0] dat2,
    input  alu_op_pkg::alu_op_e    op,
    output logic [`ALU_DATA_W-1:0] arith_out
);

    logic                   sub;
    logic [`ALU_DATA_W-1:0] b_opnd;
    logic [`ALU_DATA_W-1:0] sum;
    logic                   carry;
    logic                   lt_s;
    logic                   lt_u;

    // Everything except ADD runs the adder as a subtractor
    assign sub    = (op != alu_op_pkg::OP_ADD);
    assign b_opnd = sub ? ~dat2 : dat2;

    // Shared adder, carry in completes the two's complement
    assign {carry, sum} = {1'b0, dat1} + {1'b0, b_opnd} + {{`ALU_DATA_W{1'b0}}, sub};

    // Unsigned borrow when no carry out
    assign lt_u = ~carry;

    // Signs differ, the negative one is smaller
    // Same sign, the difference cannot overflow
    assign lt_s = (dat1[`ALU_DATA_W-1] ^ dat2[`ALU_DATA_W-1]) ?
                  dat1[`ALU_DATA_W-1] : sum[`ALU_DATA_W-1];

    always_comb begin
        arith_out = '0;
        case (op)
            alu_op_pkg::OP_ADD,
            alu_op_pkg::OP_SUB:  arith_out = sum;
            // Compare results sit in bit 0
            alu_op_pkg::OP_SLT:  arith_out = {{(`ALU_DATA_W-1){1'b0}}, lt_s};
            alu_op_pkg::OP_SLTU: arith_out = {{(`ALU_DATA_W-1){1'b0}}, lt_u};
            default:             arith_out = '0;
        endcase
    end

endmodule

//--- alu/logic_op.sv
`timescale 1ns/1ns

`include "alu_defs.svh"

module logic_op (
    input  logic [`ALU_DATA_W-1:0] dat1,
    input  logic [`ALU_DATA_W-1:0] dat2,
    input  alu_op_pkg::alu_op_e    op,
    output logic [`ALU_DATA_W-1:0] logic_out
);

    // Bitwise unit, codes 11, 14 and 15
    always_comb begin
        // Zero unless a logic code matches
        logic_out = '0;
        case (op)
            // XOR
            alu_op_pkg::OP_XOR: logic_out = dat1 ^ dat2;
            // OR
            alu_op_pkg::OP_OR:  logic_out = dat1 | dat2;
            // AND
            alu_op_pkg::OP_AND: logic_out = dat1 & dat2;
            // Arithmetic and unknown codes
            default:            logic_out = '0;
        endcase
    end

endmodule

//--- common/alu_if.sv
`timescale 1ns/1ns

`include "alu_defs.svh"

// Request from the register block to the ALU core
interface alu_req_if;
    // Single-cycle start pulse, no backpressure
    logic                   valid;
    // Raw opcode, may hold an unknown code
    logic [`ALU_OP_W-1:0]   op;
    logic [`ALU_DATA_W-1:0] dat1;
    logic [`ALU_DATA_W-1:0] dat2;

    modport src (output valid, output op, output dat1, output dat2);
    modport dst (input valid, input op, input dat1, input dat2);
endinterface

// Response from the ALU core to the result buffer
interface alu_rsp_if;
    // Single-cycle pulse, one per request
    logic                   valid;
    logic [`ALU_DATA_W-1:0] result;
    // Opcode was not recognised
    logic                   illegal;

    modport src (output valid, output result, output illegal);
    modport dst (input valid, input result, input illegal);
endinterface

//--- common/wb_regs_pkg.sv
`include "alu_defs.svh"

package wb_regs_pkg;

    // Word addresses of the register map
    typedef enum logic [`WB_ADR_W-1:0] {
        // Operands, read and write
        REG_OPA    = 3'd0,
        REG_OPB    = 3'd1,
        // Write starts an operation, read gives last opcode
        REG_CMD    = 3'd2,
        // Flags, read only
        REG_STATUS = 3'd3,
        // Last result, read only
        REG_RESULT = 3'd4
    } wb_reg_e;

    // Bit positions in the status word
    localparam int STAT_DONE    = 0;
    localparam int STAT_ILLEGAL = 1;
    localparam int STAT_ZERO    = 2;
    localparam int STAT_BUSY    = 3;

endpackage

//--- common/alu_op_pkg.sv
`include "alu_defs.svh"

package alu_op_pkg;

    // Opcode numbers seen by the ALU
    // Logic codes keep the numbering of the older logic unit
    typedef enum logic [`ALU_OP_W-1:0] {
        // Arithmetic group
        OP_ADD  = 5'd0,
        OP_SUB  = 5'd1,
        // Signed compare
        OP_SLT  = 5'd2,
        // Unsigned compare
        OP_SLTU = 5'd3,
        // Logic group
        OP_XOR  = 5'd11,
        OP_OR   = 5'd14,
        OP_AND  = 5'd15
    } alu_op_e;

    // State of the single ALU stage
    // Busy while a result sits in the output register
    typedef enum logic {
        STAGE_IDLE = 1'b0,
        STAGE_BUSY = 1'b1
    } alu_stage_e;

endpackage

//--- common/alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Operand and result width
`define ALU_DATA_W 32

// Opcode field width in the command register
`define ALU_OP_W 5

// Word address width on the Wishbone side
// Covers OPA, OPB, CMD, STATUS and RESULT
`define WB_ADR_W 3

// Bits of the status word that carry flags
// Upper bits read back as zero
`define ALU_STAT_W 4

`endif
